// File: files.f
+incdir+verilog
verilog/close_data_pkg.sv
verilog/ff1_pkg.sv
verilog/ff1_encoder.sv
verilog/close_sub.sv
verilog/close_lza.sv
verilog/close_combine.sv
verilog/fadd_close_path.sv
tests/close_checker.sv
tests/tb_fadd_close_path.sv

// File: run.sh
#!/usr/bin/env bash
# build the close path testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_fadd_close_path \
  -o sim_close_path || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/sim_close_path)"
echo "$sim_out"

# pass only when the testbench printed the pass line
echo "$sim_out" | grep -qx "Verification passed" && exit 0 || exit 1

// File: tests/tb_fadd_close_path.sv
// testbench for the fadd close path
// random operand pairs and strobe patterns, reference model of the
// difference and the true leading one, fed to the checker alongside
`default_nettype none

`include "close_consts.svh"

module tb_fadd_close_path
  import close_data_pkg::*;
  import ff1_pkg::*;
();

  localparam int SEED        = 61974;
  localparam int N_CYCLES    = 500;
  localparam int TIMEOUT     = 40;
  localparam int HALF_PERIOD = 20;

  logic        forever_cpuclk;
  logic        arst_n;
  logic        in_vld;
  close_mant_t close_adder0;
  close_mant_t close_adder1;
  close_sum_t  close_sum;
  logic        close_op_chg;
  ff1_idx_t    ff1_pred;
  ff1_vec_t    ff1_pred_onehot;
  logic        ff1_zero;
  logic        ff1_late;
  logic        out_vld;

  // model side, driven with the operands
  logic        exp_vld;
  close_sum_t  exp_sum;
  logic        exp_sign;
  ff1_idx_t    exp_idx;
  logic        exp_gt;
  logic        exp_eq;

  int          seen_cnt;
  int          err_cnt;
  int          chk_cnt;
  int          sent_cnt;
  logic        timed_out;

  fadd_close_path uut (
    .forever_cpuclk  (forever_cpuclk),
    .arst_n          (arst_n),
    .in_vld          (in_vld),
    .close_adder0    (close_adder0),
    .close_adder1    (close_adder1),
    .close_sum       (close_sum),
    .close_op_chg    (close_op_chg),
    .ff1_pred        (ff1_pred),
    .ff1_pred_onehot (ff1_pred_onehot),
    .ff1_zero        (ff1_zero),
    .ff1_late        (ff1_late),
    .out_vld         (out_vld)
  );

  close_checker chk (
    .forever_cpuclk  (forever_cpuclk),
    .arst_n          (arst_n),
    .exp_vld         (exp_vld),
    .exp_sum         (exp_sum),
    .exp_sign        (exp_sign),
    .exp_idx         (exp_idx),
    .exp_gt          (exp_gt),
    .exp_eq          (exp_eq),
    .close_sum       (close_sum),
    .close_op_chg    (close_op_chg),
    .ff1_pred        (ff1_pred),
    .ff1_pred_onehot (ff1_pred_onehot),
    .ff1_zero        (ff1_zero),
    .ff1_late        (ff1_late),
    .out_vld         (out_vld),
    .seen_cnt        (seen_cnt),
    .err_cnt         (err_cnt),
    .chk_cnt         (chk_cnt)
  );

  always #(HALF_PERIOD) forever_cpuclk = ~forever_cpuclk;

  // two's complement difference as a + ~b + 1 at the mantissa width
  function automatic close_sum_t expected_diff(close_mant_t a, close_mant_t b);
    return a + ~b + close_sum_t'(1);
  endfunction

  // position of the first set bit from the msb, CLOSE_W when empty
  function automatic int lead_index(close_sum_t d);
    close_sum_t v;
    int         idx;
    v   = d;
    idx = `CLOSE_W;
    for (int i = 0; i < `CLOSE_W; i++) begin
      if (v[`CLOSE_W-1] && idx == `CLOSE_W) begin
        idx = i;
      end
      v = v << 1;
    end
    return idx;
  endfunction

  // kind 0 mixed, 1 ordered a >= b, 2 equal
  task automatic make_pair(input int kind, output close_mant_t a, output close_mant_t b);
    logic [63:0] r;
    close_mant_t tmp;
    int          sh;
    int          pick;
    r    = {$urandom, $urandom};
    a    = r[`CLOSE_W-1:0];
    r    = {$urandom, $urandom};
    sh   = int'($urandom % `CLOSE_W);
    pick = int'($urandom % 8);
    // near operands, so the difference has a run of leading zeros
    if (pick[0]) begin
      b = a ^ (r[`CLOSE_W-1:0] >> sh);
    end else begin
      b = r[`CLOSE_W-1:0];
    end
    if (kind == 2 || (kind == 0 && pick == 0)) begin
      b = a;
    end else if (kind == 1 || pick >= 4) begin
      if (a < b) begin
        tmp = a;
        a   = b;
        b   = tmp;
      end
    end
  endtask

  // one cycle of stimulus, set up on the falling edge
  task automatic drive_item(input logic vld, input int op_kind);
    close_mant_t a;
    close_mant_t b;
    close_sum_t  d;
    @(negedge forever_cpuclk);
    in_vld  = vld;
    exp_vld = vld;
    if (vld) begin
      make_pair(op_kind, a, b);
      d            = expected_diff(a, b);
      close_adder0 = a;
      close_adder1 = b;
      exp_sum      = d;
      exp_sign     = d[`CLOSE_W-1];
      exp_idx      = ff1_idx_t'(lead_index(d));
      exp_gt       = (a > b);
      exp_eq       = (a == b);
      sent_cnt++;
    end
  endtask

  // every strobe must come back before the next test starts
  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while (seen_cnt != sent_cnt && cycles < TIMEOUT) begin
      @(posedge forever_cpuclk);
      cycles++;
    end
    if (seen_cnt != sent_cnt) begin
      $display("timeout: test %s still waits for %0d results after %0d cycles",
               name, sent_cnt - seen_cnt, cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err_before, input int n);
    if (err_cnt == err_before) begin
      $display("test %-8s ok, %0d results", name, n);
    end else begin
      $display("test %-8s FAIL, %0d errors in %0d results", name, err_cnt - err_before, n);
    end
  endtask

  // vld_kind 0 sparse, 1 bursts, 2 every cycle
  task automatic run_test(input string name, input int vld_kind, input int op_kind,
                          input int n);
    int   err_before;
    int   sent_before;
    int   burst;
    logic vld;
    err_before  = err_cnt;
    sent_before = sent_cnt;
    burst       = 0;
    for (int c = 0; c < n; c++) begin
      if (vld_kind == 0) begin
        vld = ($urandom % 3 == 0);
      end else if (vld_kind == 1) begin
        // back-to-back runs of 2 to 9 strobes with gaps between
        if (burst == 0 && $urandom % 4 == 0) begin
          burst = 2 + int'($urandom % 8);
        end
        vld = (burst > 0);
        if (burst > 0) begin
          burst--;
        end
      end else begin
        vld = 1'b1;
      end
      drive_item(vld, op_kind);
    end
    drive_item(1'b0, op_kind);
    wait_drain(name);
    report_test(name, err_before, sent_cnt - sent_before);
  endtask

  initial begin
    forever_cpuclk = 1'b0;
    arst_n         = 1'b0;
    in_vld         = 1'b0;
    close_adder0   = '0;
    close_adder1   = '0;
    exp_vld        = 1'b0;
    exp_sum        = '0;
    exp_sign       = 1'b0;
    exp_idx        = '0;
    exp_gt         = 1'b0;
    exp_eq         = 1'b0;
    sent_cnt       = 0;
    timed_out      = 1'b0;
    void'($urandom(SEED));

    // reset held 5 cycles, then idle, out_vld must stay low
    repeat (5) @(negedge forever_cpuclk);
    arst_n = 1'b1;
    repeat (4) drive_item(1'b0, 0);
    report_test("reset", 0, 0);

    run_test("sparse", 0, 0, N_CYCLES);
    if (!timed_out) run_test("burst", 1, 0, N_CYCLES);
    if (!timed_out) run_test("ordered", 2, 1, N_CYCLES);
    if (!timed_out) run_test("equal", 1, 2, N_CYCLES / 4);

    $display("results: %0d sent, %0d checked, %0d errors", sent_cnt, chk_cnt, err_cnt);
    if (!timed_out && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/close_checker.sv
// close path result checker
// queues the model values per strobe, then on the falling edge
// compares the dut outputs one cycle later and keeps the counts
`default_nettype none

`include "close_consts.svh"

module close_checker
  import close_data_pkg::*;
  import ff1_pkg::*;
(
  input  wire        forever_cpuclk,
  input  wire        arst_n,
  input  wire        exp_vld,
  input  close_sum_t exp_sum,
  input  wire        exp_sign,
  input  ff1_idx_t   exp_idx,
  input  wire        exp_gt,
  input  wire        exp_eq,
  input  close_sum_t close_sum,
  input  wire        close_op_chg,
  input  ff1_idx_t   ff1_pred,
  input  ff1_vec_t   ff1_pred_onehot,
  input  wire        ff1_zero,
  input  wire        ff1_late,
  input  wire        out_vld,
  output int         seen_cnt,
  output int         err_cnt,
  output int         chk_cnt
);

  typedef struct packed {
    close_sum_t sum;
    logic       sign;
    ff1_idx_t   idx;
    logic       gt;
    logic       eq;
  } exp_t;

  exp_t exp_q[$];
  // strobe taken at the last rising edge
  logic strobe_seen;

  initial begin
    seen_cnt    = 0;
    err_cnt     = 0;
    chk_cnt     = 0;
    strobe_seen = 1'b0;
  end

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("ERROR t=%0t: %s", $time, msg);
  endtask

  task automatic compare_result(input exp_t e);
    int       p;
    int       t;
    ff1_vec_t oh;
    p = int'(ff1_pred);
    t = int'(e.idx);
    chk_cnt++;
    if (close_sum !== e.sum)
      flag_error($sformatf("close_sum %h, expected %h", close_sum, e.sum));
    if (close_op_chg !== e.sign)
      flag_error($sformatf("close_op_chg %b, expected %b", close_op_chg, e.sign));
    // one-hot sits where the index points, empty only with ff1_zero
    if (ff1_zero === 1'b1) begin
      if (ff1_pred_onehot !== '0)
        flag_error($sformatf("ff1_pred_onehot %h with ff1_zero set", ff1_pred_onehot));
    end else if (p >= `CLOSE_W) begin
      flag_error($sformatf("ff1_pred %0d beyond the mantissa", p));
    end else begin
      oh = ff1_vec_t'(1) << (`CLOSE_W - 1 - p);
      if (ff1_pred_onehot !== oh)
        flag_error($sformatf("ff1_pred_onehot %h, expected %h", ff1_pred_onehot, oh));
    end
    // equal operands, nothing to predict
    if (e.eq && ff1_zero !== 1'b1)
      flag_error("ff1_zero low for equal operands");
    // positive difference, prediction exact or one place early
    if (e.gt) begin
      if (ff1_zero !== 1'b0) begin
        flag_error("ff1_zero high for a nonzero positive difference");
      end else if (p != t && p != t - 1) begin
        flag_error($sformatf("ff1_pred %0d, true index %0d", p, t));
      end else if (ff1_late !== (p == t - 1)) begin
        flag_error($sformatf("ff1_late %b, pred %0d, true index %0d", ff1_late, p, t));
      end
    end
  endtask

  always @(posedge forever_cpuclk) begin
    if (arst_n && exp_vld) begin
      exp_q.push_back({exp_sum, exp_sign, exp_idx, exp_gt, exp_eq});
    end
    strobe_seen <= arst_n && exp_vld;
  end

  // outputs are settled half a cycle after the register edge
  always @(negedge forever_cpuclk) begin
    exp_t e;
    if (!arst_n) begin
      if (out_vld !== 1'b0)
        flag_error("out_vld high while reset is held");
    end else if (strobe_seen) begin
      e = exp_q.pop_front();
      seen_cnt++;
      if (out_vld !== 1'b1)
        flag_error("out_vld low one cycle after in_vld");
      else
        compare_result(e);
    end else if (out_vld !== 1'b0) begin
      flag_error("out_vld high with no strobe one cycle earlier");
    end
  end

endmodule

`default_nettype wire

// File: verilog/fadd_close_path.sv
// fadd close path, one cycle
// subtractor and leading-one anticipator run side by side,
// both registered, then merged into the stage outputs
`default_nettype none

module fadd_close_path
  import close_data_pkg::*;
  import ff1_pkg::*;
(
  input  wire         forever_cpuclk,
  input  wire         arst_n,
  input  wire         in_vld,
  input  close_mant_t close_adder0,
  input  close_mant_t close_adder1,
  output close_sum_t  close_sum,
  output wire         close_op_chg,
  output ff1_idx_t    ff1_pred,
  output ff1_vec_t    ff1_pred_onehot,
  output wire         ff1_zero,
  output wire         ff1_late,
  output wire         out_vld
);

  // subtractor side
  close_sum_t sum_q;
  logic       op_chg_q;
  logic       vld_q;
  // prediction side
  ff1_idx_t   pred_q;
  ff1_vec_t   onehot_q;
  logic       zero_q;

  close_sub u_close_sub (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_vld         (in_vld),
    .close_adder0   (close_adder0),
    .close_adder1   (close_adder1),
    .sum_q          (sum_q),
    .op_chg_q       (op_chg_q),
    .vld_q          (vld_q)
  );

  close_lza u_close_lza (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_vld         (in_vld),
    .close_adder0   (close_adder0),
    .close_adder1   (close_adder1),
    .pred_q         (pred_q),
    .onehot_q       (onehot_q),
    .zero_q         (zero_q)
  );

  close_combine u_close_combine (
    .sum_q           (sum_q),
    .op_chg_q        (op_chg_q),
    .vld_q           (vld_q),
    .pred_q          (pred_q),
    .onehot_q        (onehot_q),
    .zero_q          (zero_q),
    .close_sum       (close_sum),
    .close_op_chg    (close_op_chg),
    .ff1_pred        (ff1_pred),
    .ff1_pred_onehot (ff1_pred_onehot),
    .ff1_zero        (ff1_zero),
    .ff1_late        (ff1_late),
    .out_vld         (out_vld)
  );

endmodule

`default_nettype wire

// File: verilog/close_combine.sv
// close path result merge
// lines up the registered sum and prediction and flags a prediction
// that sits one place above the true leading one
`default_nettype none

`include "close_consts.svh"

module close_combine
  import close_data_pkg::*;
  import ff1_pkg::*;
(
  input  close_sum_t sum_q,
  input  wire        op_chg_q,
  input  wire        vld_q,
  input  ff1_idx_t   pred_q,
  input  ff1_vec_t   onehot_q,
  input  wire        zero_q,
  output close_sum_t close_sum,
  output wire        close_op_chg,
  output ff1_idx_t   ff1_pred,
  output ff1_vec_t   ff1_pred_onehot,
  output wire        ff1_zero,
  output wire        ff1_late,
  output wire        out_vld
);

  // sum bits under the predicted position
  logic hit_pred;
  logic hit_next;

  assign hit_pred = |(sum_q & onehot_q);
  assign hit_next = |(sum_q & (onehot_q >> 1));

  assign close_sum       = sum_q;
  assign close_op_chg    = op_chg_q;
  assign ff1_pred        = pred_q;
  assign ff1_pred_onehot = onehot_q;
  assign ff1_zero        = zero_q;
  assign out_vld         = vld_q;

  // lza can only be one place early
  // nothing at the prediction means the one is just below
  // empty prediction has no position to miss
  assign ff1_late = ~zero_q & ~hit_pred;

  // positive nonzero result, leading one at pred or pred+1
  always_comb begin
    if (vld_q && !op_chg_q && (sum_q != '0)) begin
      a_pred_window : assert final (hit_pred || hit_next);
    end
  end

endmodule

`default_nettype wire

// File: verilog/close_lza.sv
// close path leading-zero anticipator
// builds the f-vector straight from the operands, in parallel with
// the subtractor, and registers the encoded prediction on in_vld
`default_nettype none

`include "close_consts.svh"

module close_lza
  import close_data_pkg::*;
  import ff1_pkg::*;
(
  input  wire         forever_cpuclk,
  input  wire         arst_n,
  input  wire         in_vld,
  input  close_mant_t close_adder0,
  input  close_mant_t close_adder1,
  output ff1_idx_t    pred_q,
  output ff1_vec_t    onehot_q,
  output logic        zero_q
);

  close_mant_t opc;
  close_mant_t t_vec;
  close_mant_t g_vec;
  close_mant_t z_vec;
  ff1_vec_t    f_vec;
  ff1_idx_t    pred;
  ff1_vec_t    onehot;
  logic        zero;

  // subtraction only, so C is the inverted second operand
  assign opc = ~close_adder1;

  // transfer, generate, zero per bit of A against C
  assign t_vec = close_adder0 ^ opc;
  assign g_vec = close_adder0 & opc;
  assign z_vec = ~close_adder0 & ~opc;

  // top bit has no t above it
  assign f_vec[`CLOSE_W-1] = (g_vec[`CLOSE_W-1] & ~z_vec[`CLOSE_W-2]) |
                             (z_vec[`CLOSE_W-1] & ~g_vec[`CLOSE_W-2]);

  // middle bits
  // t above: a g or z run ends here
  // no t above: the g or z string changes here
  assign f_vec[`CLOSE_W-2:1] =
      ( t_vec[`CLOSE_W-1:2] & ((g_vec[`CLOSE_W-2:1] & ~z_vec[`CLOSE_W-3:0]) |
                               (z_vec[`CLOSE_W-2:1] & ~g_vec[`CLOSE_W-3:0]))) |
      (~t_vec[`CLOSE_W-1:2] & ((g_vec[`CLOSE_W-2:1] & ~g_vec[`CLOSE_W-3:0]) |
                               (z_vec[`CLOSE_W-2:1] & ~z_vec[`CLOSE_W-3:0])));

  // bit 0, carry-in of the subtraction folded in
  assign f_vec[0] = ( t_vec[1] & g_vec[0]) |
                    (~t_vec[1] & z_vec[0]);

  ff1_encoder u_ff1_encoder (
    .f_vec  (f_vec),
    .pred   (pred),
    .onehot (onehot),
    .zero   (zero)
  );

  // lines up with sum_q in close_sub
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      pred_q   <= `FF1_IDX_RST;
      onehot_q <= `FF1_VEC_RST;
      zero_q   <= 1'b0;
    end else if (in_vld) begin
      pred_q   <= pred;
      onehot_q <= onehot;
      zero_q   <= zero;
    end
  end

  // equal operands cancel, nothing left to predict
  a_equal_empty : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    in_vld && (close_adder0 == close_adder1) |=> zero_q);

  // positive difference always leaves a set bit in the f-vector
  a_pos_nonempty : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    in_vld && (close_adder0 > close_adder1) |=> !zero_q);

endmodule

`default_nettype wire

// File: verilog/close_sub.sv
// close path subtractor
// registers close_adder0 - close_adder1, its sign and the valid bit
`default_nettype none

`include "close_consts.svh"

module close_sub
  import close_data_pkg::*;
(
  input  wire         forever_cpuclk,
  input  wire         arst_n,
  input  wire         in_vld,
  input  close_mant_t close_adder0,
  input  close_mant_t close_adder1,
  output close_sum_t  sum_q,
  output logic        op_chg_q,
  output logic        vld_q
);

  // plain wraparound subtraction, same bits as signed a - b
  close_sum_t diff;

  assign diff = close_adder0 - close_adder1;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      sum_q    <= `CLOSE_SUM_RST;
      op_chg_q <= 1'b0;
      vld_q    <= 1'b0;
    end else begin
      // valid follows the strobe, one cycle wide
      vld_q <= in_vld;
      // payload only moves on a strobe
      if (in_vld) begin
        sum_q    <= diff;
        // negative difference, operands swap later in the adder
        op_chg_q <= diff[`CLOSE_W-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ff1_encoder.sv
// find-first-one encoder
// scans the f-vector from the msb, returns index from the top,
// a one-hot at the same place, and a flag for an empty vector
`default_nettype none

`include "close_consts.svh"

module ff1_encoder
  import ff1_pkg::*;
(
  input  ff1_vec_t f_vec,
  output ff1_idx_t pred,
  output ff1_vec_t onehot,
  output logic     zero
);

  always_comb begin
    logic hit;
    // empty vector falls out as index 0, no one-hot bit
    hit    = 1'b0;
    pred   = '0;
    onehot = '0;
    // first set bit from the top wins
    for (int i = 0; i < `CLOSE_W; i++) begin
      if (!hit && f_vec[`CLOSE_W-1-i]) begin
        hit                  = 1'b1;
        pred                 = ff1_idx_t'(i);
        onehot[`CLOSE_W-1-i] = 1'b1;
      end
    end
    zero = ~hit;
  end

endmodule

`default_nettype wire

// File: verilog/ff1_pkg.sv
// leading-one prediction types
// f-vector, one-hot prediction and the index counted from the msb
`default_nettype none

`include "close_consts.svh"

package ff1_pkg;

  // bit CLOSE_W-1 is index 0, so the vector reads msb first
  typedef logic [`CLOSE_W-1:0] ff1_vec_t;

  // predicted leading-one position from the top
  typedef logic [`FF1_IDX_W-1:0] ff1_idx_t;

endpackage

`default_nettype wire

// File: verilog/close_data_pkg.sv
// close path data types
// mantissa operands and the subtraction result
`default_nettype none

`include "close_consts.svh"

package close_data_pkg;

  // aligned mantissa as it leaves the exponent compare stage
  typedef logic [`CLOSE_W-1:0] close_mant_t;

  // two's complement difference of the two mantissas
  // msb set means the second operand was larger
  typedef logic [`CLOSE_W-1:0] close_sum_t;

endpackage

`default_nettype wire

// File: verilog/close_consts.svh
// close path constants
// widths of the mantissa datapath and the leading-one prediction,
// plus the values the output registers take on reset
`ifndef CLOSE_CONSTS_SVH
`define CLOSE_CONSTS_SVH

// aligned mantissa width, hidden bit and guard bits included
`define CLOSE_W 54

// index into the mantissa from the msb, needs 6 bits for 54 places
`define FF1_IDX_W 6

// reset values of the registered results
`define CLOSE_SUM_RST {`CLOSE_W{1'b0}}
`define FF1_VEC_RST {`CLOSE_W{1'b0}}
`define FF1_IDX_RST {`FF1_IDX_W{1'b0}}

`endif
